/* gb_bus_testdata.txt */
# in: group cpu_addr rd wr boot_hidden dma_active dma_src dma_index ppu_vram ppu_oam ppu_addr
# out: cpu_sel io_sel cpu_rdata vram_addr oam_addr ext_addr ext_wr data_oe dma_rdata dma_strobe
2 0050 1 0 0 0 0000 00 0 0 0000 40 000 78 0000 0000 0050 0 0 ff 0
2 0050 1 0 1 0 0000 00 0 0 0000 20 000 ab 0000 0000 0050 0 0 ff 0
2 4000 1 0 0 0 0000 00 0 0 0000 20 000 ab 0000 0000 4000 0 0 ff 0
2 8123 1 0 0 0 0000 00 0 0 0000 10 000 89 8123 0000 8123 0 0 ff 0
2 a010 1 0 0 0 0000 00 0 0 0000 08 000 ab 0000 0000 a010 0 0 ff 0
2 c100 1 0 0 0 0000 00 0 0 0000 04 000 ab 0000 0000 c100 0 0 ff 0
2 fe10 1 0 0 0 0000 00 0 0 0000 02 000 9a 0000 fe10 fe10 0 0 ff 0
2 ff00 1 0 0 0 0000 00 0 0 0000 01 100 12 0000 0000 ff00 0 0 ff 0
2 ff02 1 0 0 0 0000 00 0 0 0000 01 080 23 0000 0000 ff02 0 0 ff 0
2 ff05 1 0 0 0 0000 00 0 0 0000 01 040 34 0000 0000 ff05 0 0 ff 0
2 ff0f 1 0 0 0 0000 00 0 0 0000 01 020 67 0000 0000 ff0f 0 0 ff 0
2 ff20 1 0 0 0 0000 00 0 0 0000 01 010 45 0000 0000 ff20 0 0 ff 0
2 ff44 1 0 0 0 0000 00 0 0 0000 01 008 56 0000 0000 ff44 0 0 ff 0
2 ff50 1 0 0 0 0000 00 0 0 0000 01 004 ff 0000 0000 ff50 0 0 ff 0
2 ff90 1 0 0 0 0000 00 0 0 0000 01 002 81 0000 0000 ff90 0 0 ff 0
2 ffff 1 0 0 0 0000 00 0 0 0000 01 001 67 0000 0000 ffff 0 0 ff 0
2 ff03 1 0 0 0 0000 00 0 0 0000 01 000 ff 0000 0000 ff03 0 0 ff 0
3 8123 1 0 0 1 8200 05 1 0 8800 10 000 ff 8800 fe05 8123 0 0 ff 0
3 8123 1 0 0 1 8200 06 0 0 0000 10 000 ff 8200 fe06 8123 0 0 89 0
3 fe10 1 0 0 1 8300 07 0 1 fe40 02 000 ff 8300 fe40 fe10 0 0 89 0
3 fe10 1 0 0 1 c000 08 0 0 0000 02 000 ff 0000 fe08 c000 0 0 ab 0
4 a010 0 1 0 1 c200 00 0 0 0000 08 000 ff 0000 fe00 c200 0 0 ab 0
4 a010 0 1 0 0 0000 00 0 0 0000 08 000 ab 0000 0000 a010 1 1 ff 0
4 c100 1 0 0 0 0000 00 0 0 0000 04 000 ab 0000 0000 c100 0 1 ff 0
4 c100 1 0 0 0 0000 00 0 0 0000 04 000 ab 0000 0000 c100 0 0 ff 0
5 ff46 0 1 0 0 0000 00 0 0 0000 01 008 56 0000 0000 ff46 1 1 ff 1
5 ff46 1 0 0 0 0000 00 0 0 0000 01 008 56 0000 0000 ff46 0 1 ff 0
5 ff47 0 1 0 0 0000 00 0 0 0000 01 008 56 0000 0000 ff47 1 1 ff 0

/* filelist.f */
gb_bus_pkg.sv
gb_map_decode.sv
bus_arbiter.sv
cpu_read_mux.sv
reset_sequencer.sv
gb_bus_top.sv
tb_gb_bus.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_gb_bus -o tb_gb_bus
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_gb_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* tb_gb_bus.sv */
`timescale 1ns/10ps

module tb_gb_bus;
	import gb_bus_pkg::*;

	localparam int clk_period   = 40;
	localparam int sample_delay = 35;

	// Every source answers with its own byte so a wrong mux choice is visible
	localparam byte_t hram_byte     = 8'h81;
	localparam byte_t joypad_byte   = 8'h12;
	localparam byte_t serial_byte   = 8'h23;
	localparam byte_t timer_byte    = 8'h34;
	localparam byte_t sound_byte    = 8'h45;
	localparam byte_t ppu_reg_byte  = 8'h56;
	localparam byte_t int_regs_byte = 8'h67;
	localparam byte_t boot_rom_byte = 8'h78;
	localparam byte_t vram_byte     = 8'h89;
	localparam byte_t oam_byte      = 8'h9a;
	localparam byte_t ext_byte      = 8'hab;

	localparam byte_t cpu_write_byte = 8'h5a;
	localparam byte_t dma_write_byte = 8'h3c;

	typedef struct packed {
		logic [3:0]  group;
		logic [15:0] cpu_addr;
		logic        cpu_rd;
		logic        cpu_wr;
		logic        hide_boot;
		logic        dma_active;
		logic [15:0] dma_src;
		logic [7:0]  dma_index;
		logic        ppu_vram;
		logic        ppu_oam;
		logic [15:0] ppu_addr;
		logic [6:0]  exp_cpu_sel;
		logic [8:0]  exp_io_sel;
		logic [7:0]  exp_cpu_rdata;
		logic [15:0] exp_vram_addr;
		logic [15:0] exp_oam_addr;
		logic [15:0] exp_ext_addr;
		logic        exp_ext_wr;
		logic        exp_data_oe;
		logic [7:0]  exp_dma_rdata;
		logic        exp_dma_strobe;
	} vector_t;

	logic          gbclk = 1'b0;
	logic          reset;
	logic          power_on;
	logic          boot_hidden;
	cpu_bus_t      cpu_req;
	dma_bus_t      dma_req;
	ppu_bus_t      ppu_req;
	periph_rdata_t periph_rdata;
	logic          core_reset;
	region_sel_t   cpu_sel;
	io_sel_t       io_sel;
	logic          dma_reg_write;
	mem_port_t     vram_port;
	mem_port_t     oam_port;
	ext_bus_t      ext_bus;
	byte_t         cpu_rdata;
	byte_t         dma_rdata;

	vector_t vectors[$];
	int      error_count  = 0;
	int      test_count   = 0;
	int      failed_tests = 0;
	int      cycle_count  = 0;
	int      cycle_limit  = 0;

	gb_bus_top i_dut (
		.gbclk        (gbclk),
		.reset        (reset),
		.power_on     (power_on),
		.boot_hidden  (boot_hidden),
		.cpu_req      (cpu_req),
		.dma_req      (dma_req),
		.ppu_req      (ppu_req),
		.periph_rdata (periph_rdata),
		.core_reset   (core_reset),
		.cpu_sel      (cpu_sel),
		.io_sel       (io_sel),
		.dma_reg_write(dma_reg_write),
		.vram_port    (vram_port),
		.oam_port     (oam_port),
		.ext_bus      (ext_bus),
		.cpu_rdata    (cpu_rdata),
		.dma_rdata    (dma_rdata)
	);

	always #(clk_period / 2) gbclk = ~gbclk;

	always @(posedge gbclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count != errors_before) begin
			failed_tests++;
			$display("test %0d, %s: failed with %0d errors", test_count, name,
				error_count - errors_before);
		end else begin
			$display("test %0d, %s: ok", test_count, name);
		end
	endtask

	function automatic string group_name(input logic [3:0] g);
		case (g)
			4'd2: return "cpu decode and read return";
			4'd3: return "video ram and oam priority";
			4'd4: return "external bus sharing";
			4'd5: return "dma start strobe";
			default: return "unknown group";
		endcase
	endfunction

	// Returns the rom, xram and wram chip selects that a DMA source address raises
	function automatic logic [2:0] dma_chip_selects(input logic active, input addr_t src);
		if (!active)
			return 3'b000;
		if (src < vram_lo)
			return 3'b100;
		if (src >= cart_ram_lo && src <= cart_ram_hi)
			return 3'b010;
		if (src >= wram_lo && src <= wram_hi)
			return 3'b001;
		return 3'b000;
	endfunction

	task automatic load_vectors;
		int      fd;
		int      code;
		int      f [21];
		string   line;
		vector_t v;
		fd = $fopen("gb_bus_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open gb_bus_testdata.txt");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 1 && line.getc(0) != "#") begin
					code = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
						f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
					if (code == 21) begin
						v = {f[0][3:0], f[1][15:0], f[2][0], f[3][0], f[4][0], f[5][0],
							f[6][15:0], f[7][7:0], f[8][0], f[9][0], f[10][15:0],
							f[11][6:0], f[12][8:0], f[13][7:0], f[14][15:0], f[15][15:0],
							f[16][15:0], f[17][0], f[18][0], f[19][7:0], f[20][0]};
						vectors.push_back(v);
					end else begin
						$display("Test data line has the wrong number of columns: %s", line);
						error_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_vector(input vector_t v);
		cpu_bus_t c;
		dma_bus_t d;
		ppu_bus_t p;
		c.addr.mem    = v.cpu_addr;
		c.rd          = v.cpu_rd;
		c.wr          = v.cpu_wr;
		c.wdata       = cpu_write_byte;
		d.active      = v.dma_active;
		d.src_addr    = v.dma_src;
		d.rd          = v.dma_active;
		d.oam_index   = v.dma_index;
		d.wr          = v.dma_active;
		d.wdata       = dma_write_byte;
		p.needs_vram  = v.ppu_vram;
		p.needs_oam   = v.ppu_oam;
		p.addr        = v.ppu_addr;
		p.rd          = v.ppu_vram || v.ppu_oam;
		cpu_req     <= c;
		dma_req     <= d;
		ppu_req     <= p;
		boot_hidden <= v.hide_boot;
	endtask

	task automatic check_vector(input vector_t v);
		region_sel_t exp_sel;
		logic [2:0]  dma_cs;
		logic [2:0]  exp_cs;
		logic        exp_ext_rd;
		exp_sel    = v.exp_cpu_sel;
		dma_cs     = dma_chip_selects(v.dma_active, v.dma_src);
		exp_cs     = {exp_sel.cart_rom, exp_sel.cart_ram, exp_sel.wram} | dma_cs;
		exp_ext_rd = (dma_cs != 3'b000) ? 1'b1 : v.cpu_rd;
		if (cpu_sel !== v.exp_cpu_sel)
			report_mismatch("cpu_sel", {9'h0, cpu_sel}, {9'h0, v.exp_cpu_sel});
		if (io_sel !== v.exp_io_sel)
			report_mismatch("io_sel", {7'h0, io_sel}, {7'h0, v.exp_io_sel});
		if (cpu_rdata !== v.exp_cpu_rdata)
			report_mismatch("cpu_rdata", {8'h0, cpu_rdata}, {8'h0, v.exp_cpu_rdata});
		if (vram_port.addr !== v.exp_vram_addr)
			report_mismatch("vram_port.addr", vram_port.addr, v.exp_vram_addr);
		if (oam_port.addr !== v.exp_oam_addr)
			report_mismatch("oam_port.addr", oam_port.addr, v.exp_oam_addr);
		if (ext_bus.addr !== v.exp_ext_addr)
			report_mismatch("ext_bus.addr", ext_bus.addr, v.exp_ext_addr);
		if (ext_bus.wr !== v.exp_ext_wr)
			report_mismatch("ext_bus.wr", {15'h0, ext_bus.wr}, {15'h0, v.exp_ext_wr});
		if (ext_bus.rd !== exp_ext_rd)
			report_mismatch("ext_bus.rd", {15'h0, ext_bus.rd}, {15'h0, exp_ext_rd});
		if ({ext_bus.cs_rom, ext_bus.cs_xram, ext_bus.cs_wram} !== exp_cs)
			report_mismatch("ext_bus chip selects",
				{13'h0, ext_bus.cs_rom, ext_bus.cs_xram, ext_bus.cs_wram}, {13'h0, exp_cs});
		if (ext_bus.data_oe !== v.exp_data_oe)
			report_mismatch("ext_bus.data_oe", {15'h0, ext_bus.data_oe}, {15'h0, v.exp_data_oe});
		if (dma_rdata !== v.exp_dma_rdata)
			report_mismatch("dma_rdata", {8'h0, dma_rdata}, {8'h0, v.exp_dma_rdata});
		if (dma_reg_write !== v.exp_dma_strobe)
			report_mismatch("dma_reg_write", {15'h0, dma_reg_write}, {15'h0, v.exp_dma_strobe});
		// A DMA that wins OAM writes its own data there
		if (v.dma_active && !v.ppu_oam) begin
			if (oam_port.wr !== 1'b1)
				report_mismatch("oam_port.wr", {15'h0, oam_port.wr}, 16'h0001);
			if (oam_port.wdata !== dma_write_byte)
				report_mismatch("oam_port.wdata", {8'h0, oam_port.wdata},
					{8'h0, dma_write_byte});
		end
	endtask

	// Starts on the edge that releases reset
	task automatic run_reset_test;
		int errors_before;
		int n;
		errors_before = error_count;
		repeat (30) @(posedge gbclk);
		#sample_delay;
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", {15'h0, core_reset}, 16'h0001);
		repeat (10) @(posedge gbclk);
		#sample_delay;
		if (core_reset !== 1'b0)
			report_mismatch("core_reset", {15'h0, core_reset}, 16'h0000);
		@(posedge gbclk);
		power_on <= 1'b0;
		@(posedge gbclk);
		#sample_delay;
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", {15'h0, core_reset}, 16'h0001);
		repeat (2) @(posedge gbclk);
		power_on <= 1'b1;
		repeat (10) @(posedge gbclk);
		#sample_delay;
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", {15'h0, core_reset}, 16'h0001);
		n = 0;
		while (core_reset === 1'b1 && n < 30) begin
			@(posedge gbclk);
			#sample_delay;
			n++;
		end
		if (core_reset !== 1'b0) begin
			$display("core_reset did not fall again after power_on came back");
			error_count++;
		end
		finish_test("reset sequence", errors_before);
	endtask

	initial begin
		int i;
		int errors_before;
		reset        <= 1'b1;
		power_on     <= 1'b1;
		boot_hidden  <= 1'b0;
		cpu_req      <= '0;
		dma_req      <= '0;
		ppu_req      <= '0;
		periph_rdata <= {hram_byte, joypad_byte, serial_byte, timer_byte, sound_byte,
			ppu_reg_byte, int_regs_byte, boot_rom_byte, vram_byte, oam_byte, ext_byte};
		load_vectors();
		if (vectors.size() == 0) begin
			$display("No test vectors were read");
			error_count++;
		end
		cycle_limit = 2 * vectors.size() + 200;
		repeat (8) @(posedge gbclk);
		reset <= 1'b0;
		run_reset_test();
		errors_before = error_count;
		for (i = 0; i < vectors.size(); i++) begin
			@(posedge gbclk);
			apply_vector(vectors[i]);
			#sample_delay;
			check_vector(vectors[i]);
			if (i == vectors.size() - 1 || vectors[i + 1].group != vectors[i].group) begin
				finish_test(group_name(vectors[i].group), errors_before);
				errors_before = error_count;
			end
		end
		$display("Summary: %0d tests, %0d failed, %0d vectors, %0d errors",
			test_count, failed_tests, vectors.size(), error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* gb_bus_top.sv */
`timescale 1ns/10ps

module gb_bus_top #(
	parameter int INIT_TICKS   = 16,
	parameter int SWITCH_TICKS = 16
) (
	input  logic                      gbclk,
	input  logic                      reset,
	input  logic                      power_on,
	input  logic                      boot_hidden,
	input  gb_bus_pkg::cpu_bus_t      cpu_req,
	input  gb_bus_pkg::dma_bus_t      dma_req,
	input  gb_bus_pkg::ppu_bus_t      ppu_req,
	input  gb_bus_pkg::periph_rdata_t periph_rdata,
	output logic                      core_reset,
	output gb_bus_pkg::region_sel_t   cpu_sel,
	output gb_bus_pkg::io_sel_t       io_sel,
	output logic                      dma_reg_write,
	output gb_bus_pkg::mem_port_t     vram_port,
	output gb_bus_pkg::mem_port_t     oam_port,
	output gb_bus_pkg::ext_bus_t      ext_bus,
	output gb_bus_pkg::byte_t         cpu_rdata,
	output gb_bus_pkg::byte_t         dma_rdata
);
	import gb_bus_pkg::*;

	region_sel_t dma_sel;
	logic        vram_busy;
	logic        oam_busy;
	logic        ext_dma_owner;

	// The pixel unit requests carry their own needs flags, so its region select stays open
	gb_map_decode i_decode (
		.cpu_req      (cpu_req),
		.dma_req      (dma_req),
		.ppu_req      (ppu_req),
		.boot_hidden  (boot_hidden),
		.cpu_sel      (cpu_sel),
		.dma_sel      (dma_sel),
		.ppu_sel      (),
		.io_sel       (io_sel),
		.dma_reg_write(dma_reg_write)
	);

	bus_arbiter i_arbiter (
		.gbclk        (gbclk),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.dma_req      (dma_req),
		.ppu_req      (ppu_req),
		.cpu_sel      (cpu_sel),
		.dma_sel      (dma_sel),
		.vram_port    (vram_port),
		.oam_port     (oam_port),
		.ext_bus      (ext_bus),
		.vram_busy    (vram_busy),
		.oam_busy     (oam_busy),
		.ext_dma_owner(ext_dma_owner)
	);

	cpu_read_mux i_read_mux (
		.cpu_sel      (cpu_sel),
		.dma_sel      (dma_sel),
		.io_sel       (io_sel),
		.vram_busy    (vram_busy),
		.oam_busy     (oam_busy),
		.ext_dma_owner(ext_dma_owner),
		.rdata        (periph_rdata),
		.cpu_rdata    (cpu_rdata),
		.dma_rdata    (dma_rdata)
	);

	reset_sequencer #(
		.INIT_TICKS  (INIT_TICKS),
		.SWITCH_TICKS(SWITCH_TICKS)
	) i_reset_seq (
		.gbclk     (gbclk),
		.reset     (reset),
		.power_on  (power_on),
		.core_reset(core_reset)
	);

endmodule

/* reset_sequencer.sv */
`timescale 1ns/10ps

module reset_sequencer #(
	parameter int INIT_TICKS   = 16,
	parameter int SWITCH_TICKS = 16
) (
	input  logic gbclk,
	input  logic reset,
	input  logic power_on,
	output logic core_reset
);
	localparam int INIT_W   = $clog2(INIT_TICKS + 1);
	localparam int SWITCH_W = $clog2(SWITCH_TICKS + 1);

	logic [INIT_W-1:0]   init_cnt;
	logic                init_done;
	logic [SWITCH_W-1:0] switch_cnt;
	logic                switch_done;
	logic                power_on_q;

	always_ff @(posedge gbclk) begin
		if (reset) begin
			init_cnt    <= '0;
			init_done   <= 1'b0;
			switch_cnt  <= '0;
			switch_done <= 1'b0;
			power_on_q  <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			power_on_q <= power_on;

			if (!init_done) begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == INIT_W'(INIT_TICKS - 1))
					init_done <= 1'b1;
			end

			// Every flip of the power switch starts the second delay over
			if (power_on != power_on_q) begin
				switch_cnt  <= '0;
				switch_done <= 1'b0;
			end else if (init_done && !switch_done) begin
				switch_cnt <= switch_cnt + 1'b1;
				if (switch_cnt == SWITCH_W'(SWITCH_TICKS - 1))
					switch_done <= 1'b1;
			end

			core_reset <= !switch_done || !power_on;
		end
	end

endmodule

/* cpu_read_mux.sv */
`timescale 1ns/10ps

module cpu_read_mux (
	input  gb_bus_pkg::region_sel_t   cpu_sel,
	input  gb_bus_pkg::region_sel_t   dma_sel,
	input  gb_bus_pkg::io_sel_t       io_sel,
	input  logic                      vram_busy,
	input  logic                      oam_busy,
	input  logic                      ext_dma_owner,
	input  gb_bus_pkg::periph_rdata_t rdata,
	output gb_bus_pkg::byte_t         cpu_rdata,
	output gb_bus_pkg::byte_t         dma_rdata
);
	import gb_bus_pkg::*;

	logic cpu_ext;

	assign cpu_ext = cpu_sel.cart_rom || cpu_sel.cart_ram || cpu_sel.wram;

	// I/O registers first, then memory regions the CPU still owns
	always_comb begin
		cpu_rdata = open_bus_value;
		if (io_sel.hram)
			cpu_rdata = rdata.hram;
		else if (io_sel.joypad)
			cpu_rdata = rdata.joypad;
		else if (io_sel.serial)
			cpu_rdata = rdata.serial;
		else if (io_sel.timer)
			cpu_rdata = rdata.timer;
		else if (io_sel.sound)
			cpu_rdata = rdata.sound;
		else if (io_sel.ppu_reg)
			cpu_rdata = rdata.ppu_reg;
		else if (io_sel.int_flag || io_sel.int_ena)
			cpu_rdata = rdata.int_regs;
		else if (cpu_sel.boot_rom)
			cpu_rdata = rdata.boot_rom;
		else if (cpu_sel.vram && !vram_busy && !dma_sel.vram)
			cpu_rdata = rdata.vram;
		else if (cpu_sel.oam && !oam_busy)
			cpu_rdata = rdata.oam;
		else if (cpu_ext && !ext_dma_owner)
			cpu_rdata = rdata.ext;
	end

	// The boot register is write only and falls through to open bus

	always_comb begin
		dma_rdata = open_bus_value;
		if (dma_sel.vram && !vram_busy)
			dma_rdata = rdata.vram;
		else if (ext_dma_owner)
			dma_rdata = rdata.ext;
	end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
	input  logic                    gbclk,
	input  logic                    reset,
	input  gb_bus_pkg::cpu_bus_t    cpu_req,
	input  gb_bus_pkg::dma_bus_t    dma_req,
	input  gb_bus_pkg::ppu_bus_t    ppu_req,
	input  gb_bus_pkg::region_sel_t cpu_sel,
	input  gb_bus_pkg::region_sel_t dma_sel,
	output gb_bus_pkg::mem_port_t   vram_port,
	output gb_bus_pkg::mem_port_t   oam_port,
	output gb_bus_pkg::ext_bus_t    ext_bus,
	output logic                    vram_busy,
	output logic                    oam_busy,
	output logic                    ext_dma_owner
);
	import gb_bus_pkg::*;

	logic ext_wr;
	logic ext_wr_q;

	// The pixel unit holds video RAM; DMA ownership is seen through dma_sel downstream
	assign vram_busy = ppu_req.needs_vram;

	// Any running DMA owns OAM as its write target
	assign oam_busy = ppu_req.needs_oam || dma_req.active;

	always_comb begin
		vram_port = '0;
		if (ppu_req.needs_vram) begin
			vram_port.addr = ppu_req.addr;
			vram_port.rd   = ppu_req.rd;
		end else if (dma_sel.vram) begin
			vram_port.addr = dma_req.src_addr;
			vram_port.rd   = dma_req.rd;
		end else if (cpu_sel.vram) begin
			vram_port.addr  = cpu_req.addr.mem;
			vram_port.rd    = cpu_req.rd;
			vram_port.wr    = cpu_req.wr;
			vram_port.wdata = cpu_req.wdata;
		end
	end

	always_comb begin
		oam_port = '0;
		if (ppu_req.needs_oam) begin
			oam_port.addr = ppu_req.addr;
			oam_port.rd   = ppu_req.rd;
		end else if (dma_req.active) begin
			oam_port.addr  = {oam_lo[15:8], dma_req.oam_index};
			oam_port.wr    = dma_req.wr;
			oam_port.wdata = dma_req.wdata;
		end else if (cpu_sel.oam) begin
			oam_port.addr  = cpu_req.addr.mem;
			oam_port.rd    = cpu_req.rd;
			oam_port.wr    = cpu_req.wr;
			oam_port.wdata = cpu_req.wdata;
		end
	end

	assign ext_dma_owner = dma_sel.cart_rom || dma_sel.cart_ram || dma_sel.wram;

	// A DMA on the external bus only ever reads
	assign ext_wr = ext_dma_owner ? 1'b0 : cpu_req.wr;

	assign ext_bus.addr    = ext_dma_owner ? dma_req.src_addr : cpu_req.addr.mem;
	assign ext_bus.rd      = ext_dma_owner ? dma_req.rd : cpu_req.rd;
	assign ext_bus.wr      = ext_wr;
	assign ext_bus.data_oe = ext_wr || ext_wr_q;
	assign ext_bus.cs_rom  = cpu_sel.cart_rom || dma_sel.cart_rom;
	assign ext_bus.cs_xram = cpu_sel.cart_ram || dma_sel.cart_ram;
	assign ext_bus.cs_wram = cpu_sel.wram || dma_sel.wram;

	// Keeps the data drive on for one cycle past the write
	always_ff @(posedge gbclk) begin
		if (reset)
			ext_wr_q <= 1'b0;
		else
			ext_wr_q <= ext_wr;
	end

endmodule

/* gb_map_decode.sv */
`timescale 1ns/10ps

module gb_map_decode (
	input  gb_bus_pkg::cpu_bus_t    cpu_req,
	input  gb_bus_pkg::dma_bus_t    dma_req,
	input  gb_bus_pkg::ppu_bus_t    ppu_req,
	input  logic                    boot_hidden,
	output gb_bus_pkg::region_sel_t cpu_sel,
	output gb_bus_pkg::region_sel_t dma_sel,
	output gb_bus_pkg::region_sel_t ppu_sel,
	output gb_bus_pkg::io_sel_t     io_sel,
	output logic                    dma_reg_write
);
	import gb_bus_pkg::*;

	byte_t io_offset;

	// One region decoder shared by all three masters
	function automatic region_sel_t region_of(addr_t a, logic boot_en);
		region_sel_t s;
		s = '0;
		if (boot_en && a < boot_rom_size)
			s.boot_rom = 1'b1;
		else if (a < vram_lo)
			s.cart_rom = 1'b1;
		else if (a >= vram_lo && a <= vram_hi)
			s.vram = 1'b1;
		else if (a >= cart_ram_lo && a <= cart_ram_hi)
			s.cart_ram = 1'b1;
		else if (a >= wram_lo && a <= wram_hi)
			s.wram = 1'b1;
		else if (a >= oam_lo && a <= oam_hi)
			s.oam = 1'b1;
		else if (a[15:8] == io_page)
			s.io = 1'b1;
		return s;
	endfunction

	assign cpu_sel = region_of(cpu_req.addr.mem, !boot_hidden);
	assign ppu_sel = region_of(ppu_req.addr, 1'b0);

	// The DMA never sees the boot ROM and decodes nothing while idle
	always_comb begin
		dma_sel = '0;
		if (dma_req.active)
			dma_sel = region_of(dma_req.src_addr, 1'b0);
	end

	assign io_offset = cpu_req.addr.io.offset;

	always_comb begin
		io_sel = '0;
		if (cpu_sel.io) begin
			if (io_offset == io_joypad)
				io_sel.joypad = 1'b1;
			else if (io_offset >= io_serial_lo && io_offset <= io_serial_hi)
				io_sel.serial = 1'b1;
			else if (io_offset >= io_timer_lo && io_offset <= io_timer_hi)
				io_sel.timer = 1'b1;
			else if (io_offset == io_int_flag)
				io_sel.int_flag = 1'b1;
			else if (io_offset >= io_sound_lo && io_offset <= io_sound_hi)
				io_sel.sound = 1'b1;
			else if (io_offset >= io_ppu_lo && io_offset <= io_ppu_hi)
				io_sel.ppu_reg = 1'b1;
			else if (io_offset == io_boot_reg)
				io_sel.boot_reg = 1'b1;
			else if (io_offset >= io_hram_lo && io_offset <= io_hram_hi)
				io_sel.hram = 1'b1;
			else if (io_offset == io_int_ena)
				io_sel.int_ena = 1'b1;
		end
	end

	// The DMA start register sits inside the video register block
	assign dma_reg_write = cpu_req.wr && io_sel.ppu_reg && io_offset == io_dma_start;

endmodule

/* gb_bus_pkg.sv */
package gb_bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	typedef struct packed {
		byte_t page;
		byte_t offset;
	} io_addr_t;

	// The CPU address is read as a memory address and as an I/O page offset
	typedef union packed {
		addr_t    mem;
		io_addr_t io;
	} cpu_addr_u;

	typedef struct packed {
		cpu_addr_u addr;
		logic      rd;
		logic      wr;
		byte_t     wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic  active;
		addr_t src_addr;
		logic  rd;
		byte_t oam_index;
		logic  wr;
		byte_t wdata;
	} dma_bus_t;

	typedef struct packed {
		logic  needs_vram;
		logic  needs_oam;
		addr_t addr;
		logic  rd;
	} ppu_bus_t;

	typedef struct packed {
		logic boot_rom;
		logic cart_rom;
		logic vram;
		logic cart_ram;
		logic wram;
		logic oam;
		logic io;
	} region_sel_t;

	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic int_flag;
		logic sound;
		logic ppu_reg;
		logic boot_reg;
		logic hram;
		logic int_ena;
	} io_sel_t;

	typedef struct packed {
		addr_t addr;
		logic  rd;
		logic  wr;
		byte_t wdata;
	} mem_port_t;

	typedef struct packed {
		addr_t addr;
		logic  rd;
		logic  wr;
		logic  data_oe;
		logic  cs_rom;
		logic  cs_xram;
		logic  cs_wram;
	} ext_bus_t;

	typedef struct packed {
		byte_t hram;
		byte_t joypad;
		byte_t serial;
		byte_t timer;
		byte_t sound;
		byte_t ppu_reg;
		byte_t int_regs;
		byte_t boot_rom;
		byte_t vram;
		byte_t oam;
		byte_t ext;
	} periph_rdata_t;

	// Memory map
	localparam addr_t boot_rom_size = 16'h0100;
	localparam addr_t vram_lo       = 16'h8000;
	localparam addr_t vram_hi       = 16'h9fff;
	localparam addr_t cart_ram_lo   = 16'ha000;
	localparam addr_t cart_ram_hi   = 16'hbfff;
	localparam addr_t wram_lo       = 16'hc000;
	localparam addr_t wram_hi       = 16'hfdff;
	localparam addr_t oam_lo        = 16'hfe00;
	localparam addr_t oam_hi        = 16'hfe9f;
	localparam byte_t io_page       = 8'hff;

	// Offsets inside the I/O page
	localparam byte_t io_joypad    = 8'h00;
	localparam byte_t io_serial_lo = 8'h01;
	localparam byte_t io_serial_hi = 8'h02;
	localparam byte_t io_timer_lo  = 8'h04;
	localparam byte_t io_timer_hi  = 8'h07;
	localparam byte_t io_int_flag  = 8'h0f;
	localparam byte_t io_sound_lo  = 8'h10;
	localparam byte_t io_sound_hi  = 8'h3f;
	localparam byte_t io_ppu_lo    = 8'h40;
	localparam byte_t io_ppu_hi    = 8'h4b;
	localparam byte_t io_dma_start = 8'h46;
	localparam byte_t io_boot_reg  = 8'h50;
	localparam byte_t io_hram_lo   = 8'h80;
	localparam byte_t io_hram_hi   = 8'hfe;
	localparam byte_t io_int_ena   = 8'hff;

	localparam byte_t open_bus_value = 8'hff;

endpackage
